//--- Bender.yml
package:
  name: vector_issue

sources:
  - hdl/vis_pkg.sv
  - hdl/uop_counter.sv
  - hdl/expansion_fsm.sv
  - hdl/pending_scoreboard.sv
  - hdl/vreg_file.sv
  - hdl/operand_forward.sv
  - hdl/vector_issue.sv
  - target: simulation
    files:
      - tb/vector_issue_props.sv
      - tb/tb_vector_issue.sv

//--- flist.f
hdl/vis_pkg.sv
hdl/uop_counter.sv
hdl/expansion_fsm.sv
hdl/pending_scoreboard.sv
hdl/vreg_file.sv
hdl/operand_forward.sv
hdl/vector_issue.sv
tb/vector_issue_props.sv
tb/tb_vector_issue.sv

//--- hdl/expansion_fsm.sv
// ================================================
// Valid and ready are plain levels, no skid buffer
// ready_o is only high on the last issuing micro-op
// ================================================
`timescale 1ns/100ps

module expansion_fsm (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic valid_i,
    input  logic ready_i,
    input  logic hazard_free_i,
    input  logic last_uop_i,
    output logic issue_o,
    output logic pop_o,
    output logic ready_o,
    output logic head_uop_o
);

    import vis_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;

    // ================================================
    // Issue decision
    // ================================================
    // Needs an instruction, a free execution side and no hazard
    assign issue_o = valid_i & ready_i & hazard_free_i;

    // First micro-op of the instruction
    assign head_uop_o = issue_o & (state_q == ST_HEAD);

    // Instruction is consumed with its last micro-op
    assign ready_o = issue_o & last_uop_i;
    assign pop_o   = valid_i & ready_o;

    // ================================================
    // State
    // ================================================
    always_comb begin
        state_d = state_q;
        if (issue_o) begin
            if (last_uop_i) begin
                state_d = ST_HEAD;
            end else begin
                state_d = ST_BODY;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_HEAD;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hdl/operand_forward.sv
// ================================================
// Purely combinational operand select per lane
// Stale lanes read as zero; the issue logic blocks them
// ================================================
`timescale 1ns/100ps

module operand_forward #(
    parameter int LANES = 8
) (
    input  vis_pkg::element_t [LANES-1:0] rf_data_i,
    input  vis_pkg::element_t [LANES-1:0] wr_data_i,
    input  logic [LANES-1:0]              fwd_i,
    input  logic [LANES-1:0]              stale_i,
    output vis_pkg::element_t [LANES-1:0] opnd_o
);

    // Writeback data has priority over the register file
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            if (fwd_i[k]) begin
                opnd_o[k] = wr_data_i[k];
            end else if (stale_i[k]) begin
                opnd_o[k] = '0;
            end else begin
                opnd_o[k] = rf_data_i[k];
            end
        end
    end

endmodule

//--- hdl/pending_scoreboard.sv
// ================================================
// One ticket per register, shared by all its lanes
// Only read-after-write hazards are checked
// ================================================
`timescale 1ns/100ps

module pending_scoreboard #(
    parameter int LANES = 8
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   issue_i,
    input  logic [LANES-1:0]       lane_therm_i,
    input  vis_pkg::vreg_addr_t    dst_i,
    input  vis_pkg::vreg_addr_t    src1_i,
    input  vis_pkg::vreg_addr_t    src2_i,
    input  vis_pkg::ticket_t       ticket_i,
    input  logic [LANES-1:0]       wr_en_i,
    input  vis_pkg::vreg_addr_t    wr_addr_i,
    input  vis_pkg::ticket_t       wr_ticket_i,
    output logic                   hazard_free_o,
    output logic [LANES-1:0]       fwd1_o,
    output logic [LANES-1:0]       fwd2_o,
    output logic [LANES-1:0]       stale1_o,
    output logic [LANES-1:0]       stale2_o,
    output logic                   all_clear_o
);

    import vis_pkg::*;

    logic [VREGS-1:0][LANES-1:0] pending_q;
    ticket_t [VREGS-1:0]         ticket_q;
    logic                        wb_match;
    logic                        src1_hit;
    logic                        src2_hit;

    // ================================================
    // Pending bits and tickets
    // ================================================
    assign wb_match = (wr_ticket_i == ticket_q[wr_addr_i]);

    // Issue to a register overrides a writeback to the same register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
            ticket_q  <= '0;
        end else begin
            for (int r = 0; r < VREGS; r++) begin
                if (issue_i && (dst_i == vreg_addr_t'(r))) begin
                    // Inactive lanes are not written by this instruction
                    pending_q[r] <= lane_therm_i;
                    ticket_q[r]  <= ticket_i;
                end else if (wb_match && (wr_addr_i == vreg_addr_t'(r))) begin
                    pending_q[r] <= pending_q[r] & ~wr_en_i;
                end
            end
        end
    end

    // ================================================
    // Forwarding and hazard check
    // ================================================
    // Writeback carries the ticket the source is waiting for
    assign src1_hit = (wr_addr_i == src1_i) & (wr_ticket_i == ticket_q[src1_i]);
    assign src2_hit = (wr_addr_i == src2_i) & (wr_ticket_i == ticket_q[src2_i]);

    assign fwd1_o = wr_en_i & {LANES{src1_hit}};
    assign fwd2_o = wr_en_i & {LANES{src2_hit}};

    // Pending and not rescued by the writeback port
    assign stale1_o = pending_q[src1_i] & ~fwd1_o;
    assign stale2_o = pending_q[src2_i] & ~fwd2_o;

    // Only active lanes can block the micro-op
    assign hazard_free_o = ~|((stale1_o | stale2_o) & lane_therm_i);

    assign all_clear_o = ~|pending_q;

endmodule

//--- hdl/uop_counter.sv
// ================================================
// LANES must be a power of two
// Remaining length is derived from vl only, not maxvl
// ================================================
`timescale 1ns/100ps

module uop_counter #(
    parameter int LANES = 8
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   issue_i,
    input  logic                   pop_i,
    input  vis_pkg::vl_t           vl_i,
    input  vis_pkg::vl_t           maxvl_i,
    output vis_pkg::vreg_addr_t    uop_idx_o,
    output logic [LANES-1:0]       lane_therm_o,
    output vis_pkg::vl_t           remaining_o,
    output logic                   last_uop_o
);

    import vis_pkg::*;

    localparam int LANE_SH = $clog2(LANES);

    vreg_addr_t  cnt_q;
    logic [9:0]  next_cover;
    logic [9:0]  next_idx;
    logic        vl_reached;
    logic        maxvl_reached;

    // Micro-op index, pop wins over issue on the last micro-op
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (pop_i) begin
            cnt_q <= '0;
        end else if (issue_i) begin
            cnt_q <= cnt_q + vreg_addr_t'(1);
        end
    end

    assign uop_idx_o   = cnt_q;
    assign remaining_o = vl_i - (vl_t'(cnt_q) << LANE_SH);

    // Active lanes of the current micro-op
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_therm_o[k] = (remaining_o > vl_t'(k));
        end
    end

    // Last when the next micro-op would already cover vl or maxvl
    assign next_idx      = 10'(cnt_q) + 10'd1;
    assign next_cover    = next_idx << LANE_SH;
    assign vl_reached    = (next_cover >= 10'(vl_i));
    assign maxvl_reached = (next_idx == 10'(maxvl_i >> LANE_SH));
    assign last_uop_o    = vl_reached | maxvl_reached;

endmodule

//--- hdl/vector_issue.sv
// ================================================
// Arithmetic instructions only, one at a time
// Outputs are valid in the issuing cycle, no output register
// ================================================
`timescale 1ns/100ps

module vector_issue #(
    parameter int LANES = vis_pkg::DEF_LANES
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    // Instruction in
    input  logic                               valid_i,
    input  vis_pkg::vreg_addr_t                instr_src1_i,
    input  vis_pkg::vreg_addr_t                instr_src2_i,
    input  vis_pkg::vreg_addr_t                instr_dst_i,
    input  vis_pkg::vl_t                       instr_vl_i,
    input  vis_pkg::vl_t                       instr_maxvl_i,
    input  vis_pkg::ticket_t                   instr_ticket_i,
    output logic                               ready_o,
    // Micro-op out
    output logic                               valid_o,
    output logic [LANES-1:0]                   lane_valid_o,
    output vis_pkg::element_t [LANES-1:0]      opnd1_o,
    output vis_pkg::element_t [LANES-1:0]      opnd2_o,
    output vis_pkg::vreg_addr_t                uop_dst_o,
    output vis_pkg::ticket_t                   uop_ticket_o,
    output logic                               head_uop_o,
    output logic                               end_uop_o,
    output vis_pkg::vl_t                       rem_vl_o,
    input  logic                               ready_i,
    // Writeback
    input  logic [LANES-1:0]                   wr_en_i,
    input  vis_pkg::vreg_addr_t                wr_addr_i,
    input  vis_pkg::element_t [LANES-1:0]      wr_data_i,
    input  vis_pkg::ticket_t                   wr_ticket_i,
    // Status
    output logic                               is_idle_o,
    output logic                               exec_finished_o
);

    import vis_pkg::*;

    vreg_addr_t               uop_idx;
    vreg_addr_t               src1;
    vreg_addr_t               src2;
    vreg_addr_t               dst;
    vl_t                      remaining;
    logic [LANES-1:0]         lane_therm;
    logic                     last_uop;
    logic                     issue;
    logic                     pop;
    logic                     hazard_free;
    logic                     all_clear;
    logic [LANES-1:0]         fwd1;
    logic [LANES-1:0]         fwd2;
    logic [LANES-1:0]         stale1;
    logic [LANES-1:0]         stale2;
    element_t [LANES-1:0]     rf_data1;
    element_t [LANES-1:0]     rf_data2;

    // Each micro-op works on the next register of the group
    assign src1 = instr_src1_i + uop_idx;
    assign src2 = instr_src2_i + uop_idx;
    assign dst  = instr_dst_i  + uop_idx;

    // ================================================
    // Expansion control
    // ================================================
    uop_counter #(.LANES(LANES)) uop_counter_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .issue_i(issue), .pop_i(pop),
        .vl_i(instr_vl_i), .maxvl_i(instr_maxvl_i), .uop_idx_o(uop_idx),
        .lane_therm_o(lane_therm), .remaining_o(remaining), .last_uop_o(last_uop)
    );

    expansion_fsm expansion_fsm_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .valid_i(valid_i), .ready_i(ready_i),
        .hazard_free_i(hazard_free), .last_uop_i(last_uop), .issue_o(issue),
        .pop_o(pop), .ready_o(ready_o), .head_uop_o(head_uop_o)
    );

    // ================================================
    // Hazards, register file and operand select
    // ================================================
    pending_scoreboard #(.LANES(LANES)) pending_scoreboard_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .issue_i(issue), .lane_therm_i(lane_therm),
        .dst_i(dst), .src1_i(src1), .src2_i(src2), .ticket_i(instr_ticket_i),
        .wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i), .wr_ticket_i(wr_ticket_i),
        .hazard_free_o(hazard_free), .fwd1_o(fwd1), .fwd2_o(fwd2),
        .stale1_o(stale1), .stale2_o(stale2), .all_clear_o(all_clear)
    );

    vreg_file #(.LANES(LANES)) vreg_file_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .rd_addr1_i(src1), .rd_addr2_i(src2),
        .rd_data1_o(rf_data1), .rd_data2_o(rf_data2), .wr_en_i(wr_en_i),
        .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i)
    );

    operand_forward #(.LANES(LANES)) operand_forward_src1_inst (
        .rf_data_i(rf_data1), .wr_data_i(wr_data_i), .fwd_i(fwd1),
        .stale_i(stale1), .opnd_o(opnd1_o)
    );

    operand_forward #(.LANES(LANES)) operand_forward_src2_inst (
        .rf_data_i(rf_data2), .wr_data_i(wr_data_i), .fwd_i(fwd2),
        .stale_i(stale2), .opnd_o(opnd2_o)
    );

    // ================================================
    // Outputs
    // ================================================
    assign valid_o         = issue;
    assign lane_valid_o    = issue ? lane_therm : '0;
    assign uop_dst_o       = dst;
    assign uop_ticket_o    = instr_ticket_i;
    assign end_uop_o       = issue & last_uop;
    assign rem_vl_o        = remaining;

    // Finished once nothing is outstanding, idle also needs no instruction
    assign exec_finished_o = all_clear;
    assign is_idle_o       = ~valid_i & all_clear;

endmodule

//--- hdl/vis_pkg.sv
// ================================================
// Constants and types shared by the issue stage
// VREGS is architectural; lane count is a top parameter
// ================================================
package vis_pkg;

    // ================================================
    // Architectural sizes
    // ================================================
    localparam int VREGS     = 32;
    localparam int DATA_W    = 32;
    localparam int TICKET_W  = 4;

    // Default lane count, must be a power of two
    localparam int DEF_LANES = 8;

    // Derived widths
    localparam int VREG_AW   = $clog2(VREGS);
    localparam int VL_W      = 7;

    // ================================================
    // Types
    // ================================================
    // Register index
    typedef logic [VREG_AW-1:0] vreg_addr_t;

    // Instruction ticket
    typedef logic [TICKET_W-1:0] ticket_t;

    // Vector length in elements, up to 64
    typedef logic [VL_W-1:0] vl_t;

    // One data element
    typedef logic [DATA_W-1:0] element_t;

    // Expansion state
    typedef enum logic {
        ST_HEAD = 1'b0,
        ST_BODY = 1'b1
    } issue_state_e;

endpackage

//--- hdl/vreg_file.sv
// ================================================
// Two combinational read ports, one write port
// Writes land at the next edge, no read bypass here
// ================================================
`timescale 1ns/100ps

module vreg_file #(
    parameter int LANES = 8
) (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  vis_pkg::vreg_addr_t                rd_addr1_i,
    input  vis_pkg::vreg_addr_t                rd_addr2_i,
    output vis_pkg::element_t [LANES-1:0]      rd_data1_o,
    output vis_pkg::element_t [LANES-1:0]      rd_data2_o,
    input  logic [LANES-1:0]                   wr_en_i,
    input  vis_pkg::vreg_addr_t                wr_addr_i,
    input  vis_pkg::element_t [LANES-1:0]      wr_data_i
);

    import vis_pkg::*;

    // Register storage, one element per lane
    element_t [VREGS-1:0][LANES-1:0] regs_q;

    // ================================================
    // Element write port
    // ================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            regs_q <= '0;
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (wr_en_i[k]) begin
                    regs_q[wr_addr_i][k] <= wr_data_i[k];
                end
            end
        end
    end

    // ================================================
    // Read ports
    // ================================================
    assign rd_data1_o = regs_q[rd_addr1_i];
    assign rd_data2_o = regs_q[rd_addr2_i];

endmodule

//--- tb/tb_vector_issue.sv
// ================================================
// Directed and random instructions, 8 lanes
// Sources and destinations kept apart so no self hazards
// ================================================
`timescale 1ns/100ps

module tb_vector_issue;

    import vis_pkg::*;

    localparam int LANES = 8;
    localparam int TMO   = 40;

    logic clk_i, rstn_i, valid_i, ready_o, valid_o, ready_i;
    logic head_uop_o, end_uop_o, is_idle_o, exec_finished_o;
    vreg_addr_t instr_src1_i, instr_src2_i, instr_dst_i, uop_dst_o, wr_addr_i;
    vl_t instr_vl_i, instr_maxvl_i, rem_vl_o;
    ticket_t instr_ticket_i, uop_ticket_o, wr_ticket_i;
    logic [LANES-1:0] lane_valid_o, wr_en_i;
    element_t [LANES-1:0] opnd1_o, opnd2_o, wr_data_i;

    // Reference register file and outstanding destinations
    element_t ref_rf [VREGS][LANES];
    ticket_t  ref_tkt [VREGS];
    logic     ref_pend [VREGS];
    logic [31:0] rng;

    vector_issue #(.LANES(LANES)) vector_issue_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Bound assertion failures end the run at once
    always @(vector_issue_inst.vector_issue_props_inst.fail_cnt) begin
        if (vector_issue_inst.vector_issue_props_inst.fail_cnt != 0) begin
            $display("Simulation failed");
            $fatal(1, "bound assertion failed");
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "check %s failed", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "no progress");
    endtask

    // Edge plus 10 ns; writeback lands in the reference at the edge
    task automatic next_cycle();
        @(posedge clk_i);
        for (int k = 0; k < LANES; k++) begin
            if (wr_en_i[k]) begin
                ref_rf[wr_addr_i][k] = wr_data_i[k];
            end
        end
        if (wr_en_i != '0 && ref_pend[wr_addr_i] && ref_tkt[wr_addr_i] == wr_ticket_i) begin
            ref_pend[wr_addr_i] = 1'b0;
        end
        #10;
        wr_en_i = '0;
    endtask

    task automatic drive_wb(input vreg_addr_t addr, input ticket_t tkt,
                            input logic [LANES-1:0] mask);
        wr_en_i     = mask;
        wr_addr_i   = addr;
        wr_ticket_i = tkt;
        for (int k = 0; k < LANES; k++) begin
            wr_data_i[k] = next_rand();
        end
    endtask

    task automatic drive_instr(input vreg_addr_t s1, input vreg_addr_t s2, input vreg_addr_t d,
                               input vl_t vl, input vl_t maxvl, input ticket_t tkt);
        valid_i        = 1'b1;
        ready_i        = 1'b1;
        instr_src1_i   = s1;
        instr_src2_i   = s2;
        instr_dst_i    = d;
        instr_vl_i     = vl;
        instr_maxvl_i  = maxvl;
        instr_ticket_i = tkt;
    endtask

    // Back-pressure window, remaining length must not move
    task automatic hold_ready(input int cycles, input vl_t exp_rem);
        ready_i = 1'b0;
        repeat (cycles) begin
            @(negedge clk_i);
            expect_eq("hold_valid", 0, valid_o);
            expect_eq("hold_rem_vl", exp_rem, rem_vl_o);
            next_cycle();
        end
        ready_i = 1'b1;
    endtask

    task automatic run_instr(input vreg_addr_t s1, input vreg_addr_t s2, input vreg_addr_t d,
                             input vl_t vl, input vl_t maxvl, input ticket_t tkt,
                             input int hold);
        int idx;
        int tmo;
        int len;
        bit done;
        idx  = 0;
        tmo  = 0;
        done = 1'b0;
        len  = (vl < maxvl) ? int'(vl) : int'(maxvl);
        drive_instr(s1, s2, d, vl, maxvl, tkt);
        while (!done) begin
            @(negedge clk_i);
            if (valid_o) begin
                for (int k = 0; k < LANES; k++) begin
                    if (k < len - idx * LANES) begin
                        expect_eq("opnd1", ref_rf[vreg_addr_t'(s1 + idx)][k], opnd1_o[k]);
                        expect_eq("opnd2", ref_rf[vreg_addr_t'(s2 + idx)][k], opnd2_o[k]);
                    end
                end
                expect_eq("uop_dst", vreg_addr_t'(d + idx), uop_dst_o);
                expect_eq("uop_ticket", tkt, uop_ticket_o);
                ref_pend[vreg_addr_t'(d + idx)] = 1'b1;
                ref_tkt[vreg_addr_t'(d + idx)]  = tkt;
                idx++;
                done = ready_o;
            end
            tmo++;
            if (tmo > TMO) begin
                timeout_fail("instruction pop");
            end
            next_cycle();
            if (idx == 1 && hold > 0 && !done) begin
                hold_ready(hold, vl - vl_t'(LANES));
                hold = 0;
            end
        end
        valid_i = 1'b0;
    endtask

    task automatic clear_pending();
        for (int r = 0; r < VREGS; r++) begin
            if (ref_pend[r]) begin
                drive_wb(vreg_addr_t'(r), ref_tkt[r], '1);
                next_cycle();
            end
        end
        @(negedge clk_i);
        expect_eq("finished", 1, exec_finished_o);
        next_cycle();
    endtask

    initial begin
        rng = 32'hc7fc74f1;
        {rstn_i, valid_i, ready_i, instr_src1_i, instr_src2_i, instr_dst_i} = '0;
        {instr_vl_i, instr_maxvl_i, instr_ticket_i} = '0;
        {wr_en_i, wr_addr_i, wr_data_i, wr_ticket_i} = '0;
        for (int r = 0; r < VREGS; r++) begin
            ref_pend[r] = 1'b0;
            ref_tkt[r]  = '0;
            for (int k = 0; k < LANES; k++) begin
                ref_rf[r][k] = '0;
            end
        end
        repeat (5) @(posedge clk_i);
        #10;
        rstn_i = 1'b1;

        // Fill source registers, second pass with element enables
        for (int p = 0; p < 32; p++) begin
            drive_wb(vreg_addr_t'(p % 16), '0, (p < 16) ? {LANES{1'b1}} : LANES'(next_rand()));
            next_cycle();
        end

        run_instr(5'd1, 5'd2, 5'd20, 7'd8, 7'd64, 4'd1, 0);
        clear_pending();
        run_instr(5'd0, 5'd4, 5'd16, 7'd13, 7'd64, 4'd2, 0);
        clear_pending();
        run_instr(5'd5, 5'd6, 5'd18, 7'd40, 7'd16, 4'd3, 0);
        clear_pending();
        run_instr(5'd2, 5'd7, 5'd24, 7'd24, 7'd64, 4'd4, 4);
        clear_pending();

        repeat (10) begin
            run_instr(vreg_addr_t'(next_rand() % 8), vreg_addr_t'(next_rand() % 8),
                      vreg_addr_t'(16 + next_rand() % 8), vl_t'(next_rand() % 64 + 1),
                      vl_t'(8 * (next_rand() % 8 + 1)), ticket_t'(next_rand()),
                      int'(next_rand() % 3));
            clear_pending();
        end

        // Read-after-write on register 10, then a stale and a matching writeback
        run_instr(5'd1, 5'd2, 5'd10, 7'd8, 7'd64, 4'd5, 0);
        drive_instr(5'd10, 5'd3, 5'd11, 7'd8, 7'd64, 4'd6);
        repeat (3) begin
            @(negedge clk_i);
            expect_eq("hazard_stall", 0, valid_o);
            next_cycle();
        end
        drive_wb(5'd10, 4'd9, '1);
        @(negedge clk_i);
        expect_eq("stale_stall", 0, valid_o);
        expect_eq("stale_finished", 0, exec_finished_o);
        next_cycle();
        drive_wb(5'd10, 4'd5, '1);
        @(negedge clk_i);
        expect_eq("fwd_issue", 1, valid_o);
        for (int k = 0; k < LANES; k++) begin
            expect_eq("fwd_opnd1", wr_data_i[k], opnd1_o[k]);
            expect_eq("fwd_opnd2", ref_rf[3][k], opnd2_o[k]);
        end
        ref_pend[11] = 1'b1;
        ref_tkt[11]  = 4'd6;
        next_cycle();
        valid_i = 1'b0;
        clear_pending();

        if (vector_issue_inst.vector_issue_props_inst.fail_cnt != 0) begin
            $display("Bound assertions failed %0d times",
                     vector_issue_inst.vector_issue_props_inst.fail_cnt);
            $display("Simulation failed");
            $fatal(1, "bound assertion failures");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- tb/vector_issue_props.sv
// ================================================
// Bound to vector_issue; assumes maxvl is a multiple of LANES
// Failures are counted in fail_cnt for the testbench
// ================================================
`timescale 1ns/100ps

module vector_issue_props #(
    parameter int LANES = 8
) (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               valid_i,
    input logic               ready_o,
    input logic               valid_o,
    input logic               head_uop_o,
    input logic               end_uop_o,
    input logic               is_idle_o,
    input logic               exec_finished_o,
    input vis_pkg::vl_t       instr_vl_i,
    input vis_pkg::vl_t       instr_maxvl_i,
    input logic [LANES-1:0]   lane_valid_o
);

    import vis_pkg::*;

    int               fail_cnt = 0;
    int               uop_cnt;
    int               len;
    int               exp_uops;
    logic [LANES-1:0] last_therm;

    // Elements covered and micro-ops expected for the current instruction
    always_comb begin
        len        = (instr_vl_i < instr_maxvl_i) ? int'(instr_vl_i) : int'(instr_maxvl_i);
        exp_uops   = (len + LANES - 1) / LANES;
        last_therm = {LANES{1'b1}} >> (LANES * exp_uops - len);
    end

    // Issues seen since the last pop
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            uop_cnt <= 0;
        end else if (ready_o) begin
            uop_cnt <= 0;
        end else if (valid_o) begin
            uop_cnt <= uop_cnt + 1;
        end
    end

    // ================================================
    // Reset and expansion checks
    // ================================================
    reset_outputs: assert property (@(posedge clk_i) (!rstn_i || $rose(rstn_i)) |->
        (!valid_o && !ready_o && is_idle_o && exec_finished_o))
        else begin
            $error("outputs wrong during or just after reset");
            fail_cnt++;
        end

    head_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_o || head_uop_o) |-> (head_uop_o == (valid_o && uop_cnt == 0)))
        else begin
            $error("head marker not on the first micro-op only");
            fail_cnt++;
        end

    end_last: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_o || end_uop_o) |-> (end_uop_o == (valid_o && uop_cnt == exp_uops - 1)))
        else begin
            $error("end marker not on micro-op %0d of %0d", uop_cnt, exp_uops);
            fail_cnt++;
        end

    ready_last: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_o || ready_o) |-> (ready_o == (valid_o && uop_cnt == exp_uops - 1)))
        else begin
            $error("ready_o not on micro-op %0d of %0d", uop_cnt, exp_uops);
            fail_cnt++;
        end

    last_lanes: assert property (@(posedge clk_i) disable iff (!rstn_i)
        end_uop_o |-> (lane_valid_o == last_therm))
        else begin
            $error("last micro-op lanes %b, remaining thermometer %b", lane_valid_o, last_therm);
            fail_cnt++;
        end

endmodule

bind vector_issue vector_issue_props #(.LANES(LANES)) vector_issue_props_inst (.*);
